/* include/calc_defines.svh */
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// cycles each keypad column stays driven low
// 50000 cycles is 1 ms at 50 MHz
`define CALC_SCAN_CYCLES 50000

// stable cycles needed before a press or a release is believed
// 500000 cycles is 10 ms at 50 MHz
`define CALC_DEBOUNCE_CYCLES 500000

// operand, accumulator and display width
`define CALC_WIDTH 16

// keypad geometry
`define CALC_KEYPAD_ROWS 4
`define CALC_KEYPAD_COLS 4

`endif

/* hw/calc_pkg.sv */
package calc_pkg;

    // what kind of key the scanner has decoded
    typedef enum logic [2:0] {
        KEY_DIGIT  = 3'd0,  // 0 to 9, value on key_digit
        KEY_OP     = 3'd1,  // add, subtract or multiply on key_op
        KEY_EQUAL  = 3'd2,  // evaluate pending operation
        KEY_CLEAR  = 3'd3,  // pound key, wipes the calculator
        KEY_NEGATE = 3'd4   // minus-symbol key, flips sign of entry
    } key_class_t;

    // arithmetic operation, also the latched pending operator
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,  // nothing pending
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3   // low half of product kept
    } calc_op_t;

    // keypad scanner FSM
    typedef enum logic [2:0] {
        SCAN             = 3'd0,  // walk the low column across the keypad
        PRESS_DEBOUNCE   = 3'd1,  // column frozen, count stable pressed cycles
        HOLD             = 3'd2,  // key_valid high until the controller acks
        WAIT_RELEASE     = 3'd3,  // wait for every row to read high
        RELEASE_DEBOUNCE = 3'd4   // count stable released cycles
    } scan_state_t;

endpackage

/* hw/calc_alu.sv */
`include "calc_defines.svh"

module calc_alu (
    input  logic signed [`CALC_WIDTH-1:0] a,       // accumulator
    input  logic signed [`CALC_WIDTH-1:0] b,       // current entry
    input  calc_pkg::calc_op_t            op,      // pending operator
    output logic signed [`CALC_WIDTH-1:0] result
);
    import calc_pkg::*;

    localparam int W = `CALC_WIDTH;

    logic signed [W-1:0] product;  // low half of the full product, wraps
    logic signed [W-1:0] sum;
    logic signed [W-1:0] diff;

    assign product = a * b;
    assign sum     = a + b;  // wraps
    assign diff    = a - b;  // wraps

    always_comb begin
        case (op)
            OP_ADD:  result = sum;
            OP_SUB:  result = diff;
            OP_MUL:  result = product;
            default: result = b;  // nothing pending, pass entry through
        endcase
    end

endmodule

/* hw/keypad_scanner.sv */
`include "calc_defines.svh"

module keypad_scanner #(
    parameter int SCAN_CYCLES     = `CALC_SCAN_CYCLES,     // cycles per column
    parameter int DEBOUNCE_CYCLES = `CALC_DEBOUNCE_CYCLES  // stable cycles to accept
) (
    input  logic                         clk,
    input  logic                         nRST,       // async, active low
    input  logic [`CALC_KEYPAD_ROWS-1:0] row_in,     // pulled up rows
    output logic [`CALC_KEYPAD_COLS-1:0] col_out,    // one column low at a time
    output logic                         key_valid,  // level, held until acked
    input  logic                         key_ack,    // strobe from controller
    output calc_pkg::key_class_t         key_class,
    output logic [3:0]                   key_digit,
    output calc_pkg::calc_op_t           key_op
);
    import calc_pkg::*;

    localparam int ROWS   = `CALC_KEYPAD_ROWS;
    localparam int COLS   = `CALC_KEYPAD_COLS;
    localparam int COL_W  = $clog2(COLS);
    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);
    localparam int DEB_W  = $clog2(DEBOUNCE_CYCLES + 1);

    scan_state_t       state;
    logic [COL_W-1:0]  col_idx;      // column currently driven low
    logic [SCAN_W-1:0] scan_timer;   // cycles spent on this column
    logic [DEB_W-1:0]  deb_cnt;      // shared by press and release debounce
    logic [ROWS-1:0]   row_meta;     // first synchronizer stage
    logic [ROWS-1:0]   row_sync;     // second stage, safe to use
    logic              row_pressed;  // some row reads low
    logic              scan_last;    // last cycle on this column
    logic              deb_last;     // debounce count about to complete
    logic              press_done;   // press accepted this cycle
    logic [3:0]        key_idx;      // row * 4 + col
    key_class_t        dec_class;
    logic [3:0]        dec_digit;
    calc_op_t          dec_op;

    // first low row wins, loop runs downward so the lowest index is assigned last
    function automatic logic [3:0] encode_key(input logic [ROWS-1:0] row,
                                              input logic [COL_W-1:0] col);
        logic [3:0] idx;
        idx = 4'hE;  // never used, a low row is guaranteed here
        for (int r = ROWS - 1; r >= 0; r--) begin
            if (!row[r])
                idx = 4'(r * COLS) + 4'(col);
        end
        return idx;
    endfunction

    // two flops on the rows, idle level is high
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= '1;
            row_sync <= '1;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    assign row_pressed = ~&row_sync;
    assign scan_last   = (scan_timer == SCAN_W'(SCAN_CYCLES - 1));
    assign deb_last    = (deb_cnt == DEB_W'(DEBOUNCE_CYCLES - 1));
    assign press_done  = (state == PRESS_DEBOUNCE) && row_pressed && deb_last;
    assign key_valid   = (state == HOLD);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= SCAN;
            col_idx    <= '0;
            scan_timer <= '0;
            deb_cnt    <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (row_pressed) begin  // freeze column, start counting
                        state      <= PRESS_DEBOUNCE;
                        scan_timer <= '0;
                        deb_cnt    <= '0;
                    end else if (scan_last) begin
                        scan_timer <= '0;
                        col_idx    <= col_idx + 1'b1;  // wraps after last column
                    end else begin
                        scan_timer <= scan_timer + 1'b1;
                    end
                end
                PRESS_DEBOUNCE: begin
                    if (!row_pressed) begin  // bounce or stale row, start over
                        state   <= SCAN;
                        deb_cnt <= '0;
                    end else if (deb_last) begin
                        state   <= HOLD;
                        deb_cnt <= '0;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                HOLD: begin
                    if (key_ack)
                        state <= WAIT_RELEASE;  // key_valid drops here
                end
                WAIT_RELEASE: begin
                    if (!row_pressed) begin
                        state   <= RELEASE_DEBOUNCE;
                        deb_cnt <= '0;
                    end
                end
                RELEASE_DEBOUNCE: begin
                    if (row_pressed) begin  // still bouncing
                        state   <= WAIT_RELEASE;
                        deb_cnt <= '0;
                    end else if (deb_last) begin
                        state   <= SCAN;
                        deb_cnt <= '0;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                default: state <= SCAN;
            endcase
        end
    end

    assign key_idx = encode_key(row_sync, col_idx);

    // key map, row major from the top left
    always_comb begin
        dec_class = KEY_DIGIT;
        dec_digit = 4'd0;
        dec_op    = OP_NONE;
        case (key_idx)
            4'h0: dec_digit = 4'd1;
            4'h1: dec_digit = 4'd2;
            4'h2: dec_digit = 4'd3;
            4'h3: begin dec_class = KEY_OP; dec_op = OP_ADD; end
            4'h4: dec_digit = 4'd4;
            4'h5: dec_digit = 4'd5;
            4'h6: dec_digit = 4'd6;
            4'h7: begin dec_class = KEY_OP; dec_op = OP_SUB; end
            4'h8: dec_digit = 4'd7;
            4'h9: dec_digit = 4'd8;
            4'hA: dec_digit = 4'd9;
            4'hB: begin dec_class = KEY_OP; dec_op = OP_MUL; end
            4'hC: dec_class = KEY_EQUAL;
            4'hD: dec_digit = 4'd0;
            4'hE: dec_class = KEY_CLEAR;   // pound
            4'hF: dec_class = KEY_NEGATE;  // minus symbol
            default: ;
        endcase
    end

    // key fields captured once, stable for all of HOLD
    always_ff @(posedge clk) begin
        if (press_done) begin
            key_class <= dec_class;
            key_digit <= dec_digit;
            key_op    <= dec_op;
        end
    end

    always_comb begin
        col_out          = '1;
        col_out[col_idx] = 1'b0;  // active low column drive
    end

endmodule

/* hw/calc_controller.sv */
`include "calc_defines.svh"

module calc_controller (
    input  logic                          clk,
    input  logic                          nRST,           // async, active low
    input  logic                          key_valid,      // level from scanner
    output logic                          key_ack,        // one cycle strobe
    input  calc_pkg::key_class_t          key_class,
    input  logic [3:0]                    key_digit,
    input  calc_pkg::calc_op_t            key_op,
    output logic signed [`CALC_WIDTH-1:0] display_value,
    output logic                          result_valid    // pulses once per equal
);
    import calc_pkg::*;

    localparam int W = `CALC_WIDTH;
    localparam logic signed [W-1:0] TEN = W'(10);

    logic signed [W-1:0] entry;        // operand being typed
    logic signed [W-1:0] acc;          // running result
    calc_op_t            pend_op;      // operator waiting for its right operand
    logic                show_result;  // display shows acc instead of entry
    logic                valid_seen;   // key_valid one cycle ago
    logic signed [W-1:0] alu_result;
    logic signed [W-1:0] digit_ext;
    logic signed [W-1:0] entry_digit;  // entry with the new digit appended

    calc_alu u_alu (
        .a      (acc),
        .b      (entry),
        .op     (pend_op),
        .result (alu_result)
    );

    // ack on the rising edge of key_valid only
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            valid_seen <= 1'b0;
        else
            valid_seen <= key_valid;
    end

    assign key_ack = key_valid && !valid_seen;

    assign digit_ext   = {{(W - 4){1'b0}}, key_digit};
    assign entry_digit = entry * TEN + digit_ext;  // wraps to W bits

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry        <= '0;
            acc          <= '0;
            pend_op      <= OP_NONE;
            show_result  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;  // strobe default
            if (key_ack) begin
                case (key_class)
                    KEY_DIGIT: begin
                        if (show_result)
                            entry <= digit_ext;  // fresh number after a result
                        else
                            entry <= entry_digit;
                        show_result <= 1'b0;
                    end
                    KEY_NEGATE: begin
                        if (show_result)
                            entry <= -acc;  // result becomes the new entry
                        else
                            entry <= -entry;
                        show_result <= 1'b0;
                    end
                    KEY_OP: begin
                        // alu passes entry through when nothing is pending
                        if (!show_result)
                            acc <= alu_result;
                        pend_op     <= key_op;
                        entry       <= '0;
                        show_result <= 1'b0;
                    end
                    KEY_EQUAL: begin
                        acc          <= alu_result;
                        entry        <= alu_result;  // a following op chains on it
                        pend_op      <= OP_NONE;
                        show_result  <= 1'b1;
                        result_valid <= 1'b1;
                    end
                    KEY_CLEAR: begin
                        entry       <= '0;
                        acc         <= '0;
                        pend_op     <= OP_NONE;
                        show_result <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign display_value = show_result ? acc : entry;

endmodule

/* hw/calculator_top.sv */
`include "calc_defines.svh"

module calculator_top #(
    parameter int SCAN_CYCLES     = `CALC_SCAN_CYCLES,
    parameter int DEBOUNCE_CYCLES = `CALC_DEBOUNCE_CYCLES
) (
    input  logic                          clk,
    input  logic                          nRST,           // async, active low
    input  logic [`CALC_KEYPAD_ROWS-1:0]  row_in,         // keypad rows, pulled up
    output logic [`CALC_KEYPAD_COLS-1:0]  col_out,        // keypad columns
    output logic signed [`CALC_WIDTH-1:0] display_value,
    output logic                          result_valid
);
    import calc_pkg::*;

    // scanner to controller handshake
    logic       key_valid;
    logic       key_ack;
    key_class_t key_class;
    logic [3:0] key_digit;
    calc_op_t   key_op;

    keypad_scanner #(
        .SCAN_CYCLES     (SCAN_CYCLES),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_scanner (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_valid (key_valid),
        .key_ack   (key_ack),
        .key_class (key_class),
        .key_digit (key_digit),
        .key_op    (key_op)
    );

    calc_controller u_controller (
        .clk           (clk),
        .nRST          (nRST),
        .key_valid     (key_valid),
        .key_ack       (key_ack),
        .key_class     (key_class),
        .key_digit     (key_digit),
        .key_op        (key_op),
        .display_value (display_value),
        .result_valid  (result_valid)
    );

endmodule

/* tests/calculator_assert.sv */
module calculator_assert (
    input logic                 clk,
    input logic                 nRST,
    input logic [3:0]           col_out,
    input logic                 key_valid,
    input logic                 key_ack,
    input calc_pkg::key_class_t key_class,
    input logic [3:0]           key_digit,
    input calc_pkg::calc_op_t   key_op
);

    // exactly one column driven low
    one_col_low: assert property (@(posedge clk) disable iff (!nRST)
        $countones(~col_out) == 1)
        else $error("col_out is %b, not exactly one column low", col_out);

    // pending key holds its level and its fields until acked
    key_held: assert property (@(posedge clk) disable iff (!nRST)
        key_valid && !key_ack |=> key_valid && $stable(key_class)
                                  && $stable(key_digit) && $stable(key_op))
        else $error("key_valid or key fields changed before key_ack");

    // ack drops the level on the next edge
    valid_drop: assert property (@(posedge clk) disable iff (!nRST)
        key_valid && key_ack |=> !key_valid)
        else $error("key_valid still high after key_ack");

endmodule

bind keypad_scanner calculator_assert u_scanner_assert (
    .clk       (clk),
    .nRST      (nRST),
    .col_out   (col_out),
    .key_valid (key_valid),
    .key_ack   (key_ack),
    .key_class (key_class),
    .key_digit (key_digit),
    .key_op    (key_op)
);

/* tests/calculator_tb.sv */
module calculator_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;   // inputs move this long after the rising edge
    localparam int RESET_CYCLES   = 16;
    localparam int HOLD_CYCLES    = 60;   // key held down
    localparam int RELEASE_CYCLES = 60;   // key up before the next press
    localparam int LONG_CYCLES    = 240;  // long press, still one key
    localparam int SHORT_CYCLES   = 12;   // below the debounce length
    localparam int RAND_ITERS     = 6;

    // presses per test group, long and short presses counted by their length
    localparam int DIGIT_PRESSES    = 12;
    localparam int RAND_PRESSES     = RAND_ITERS * 9;  // clear, 3 digits, op, 3 digits, equal
    localparam int CHAIN_PRESSES    = 10;
    localparam int NEGATE_PRESSES   = 11;
    localparam int DEBOUNCE_PRESSES = 7;
    localparam int PRESS_UNITS      = DIGIT_PRESSES + RAND_PRESSES + CHAIN_PRESSES
                                      + NEGATE_PRESSES + DEBOUNCE_PRESSES;
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + PRESS_UNITS * 120 * 12 / 10;

    logic               clk = 1'b0;
    logic               nRST;
    logic [3:0]         row_in;
    logic [3:0]         col_out;
    logic signed [15:0] display_value;
    logic               result_valid;

    int                 held_key;                  // key index, -1 when no key is down
    int                 ack_count   = 0;           // keys taken by the controller
    int                 pulse_count = 0;           // result_valid pulses seen
    int                 cycle_count = 0;
    logic signed [15:0] expected_display = '0;     // model view after the last key
    logic signed [15:0] ref_entry = '0;            // shadow calculator state
    logic signed [15:0] ref_acc   = '0;
    int                 ref_op    = 0;             // 0 none, 1 add, 2 sub, 3 mul
    bit                 ref_show  = 1'b0;          // shadow display shows the result

    calculator_top #(
        .SCAN_CYCLES     (8),
        .DEBOUNCE_CYCLES (20)
    ) UUT (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .display_value (display_value),
        .result_valid  (result_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // keypad: the held key pulls its row low while its column is driven low
    always_comb begin
        row_in = 4'b1111;
        if (held_key >= 0 && col_out[held_key % 4] == 1'b0)
            row_in[held_key / 4] = 1'b0;
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic signed [15:0] alu_model(input int op,
                                                    input logic signed [15:0] a,
                                                    input logic signed [15:0] b);
        case (op)
            1:       return a + b;
            2:       return a - b;
            3:       return a * b;  // low 16 bits only
            default: return b;      // nothing pending
        endcase
    endfunction

    // applies one key to the shadow model, returns the expected display
    function automatic logic signed [15:0] model_key(input int idx);
        int row;
        int col;
        row = idx / 4;
        col = idx % 4;
        if (idx == 12) begin  // equal
            ref_acc   = alu_model(ref_op, ref_acc, ref_entry);
            ref_entry = ref_acc;
            ref_op    = 0;
            ref_show  = 1'b1;
        end else if (idx == 14) begin  // clear
            ref_entry = '0;
            ref_acc   = '0;
            ref_op    = 0;
            ref_show  = 1'b0;
        end else if (idx == 15) begin  // negate, a shown result becomes the entry
            ref_entry = ref_show ? -ref_acc : -ref_entry;
            ref_show  = 1'b0;
        end else if (col == 3) begin  // operator column, add sub mul from the top
            if (!ref_show)
                ref_acc = alu_model(ref_op, ref_acc, ref_entry);
            ref_op    = row + 1;
            ref_entry = '0;
            ref_show  = 1'b0;
        end else begin
            int d;
            d = (idx == 13) ? 0 : row * 3 + col + 1;
            ref_entry = ref_show ? 16'(d) : 16'(ref_entry * 10 + d);  // wraps
            ref_show  = 1'b0;
        end
        return ref_show ? ref_acc : ref_entry;
    endfunction

    function automatic int digit_key(input int d);
        if (d == 0)
            return 13;
        return ((d - 1) / 3) * 4 + (d - 1) % 3;
    endfunction

    // press, hold, release, end on a falling edge where outputs are settled
    task automatic hold_key(input int idx, input int cycles);
        @(posedge clk);
        #DRIVE_DELAY held_key = idx;
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY held_key = -1;
        repeat (RELEASE_CYCLES) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic press_key(input int idx, input int cycles = HOLD_CYCLES);
        int acks_before;
        int pulses_before;
        acks_before      = ack_count;
        pulses_before    = pulse_count;
        expected_display = model_key(idx);
        hold_key(idx, cycles);
        check_value("key_ack count", ack_count - acks_before, 1);  // one key per press
        check_value("result_valid pulses", pulse_count - pulses_before, (idx == 12) ? 1 : 0);
        check_value("display_value", display_value, expected_display);
    endtask

    // short press started just after the key's column goes low, so the scanner sees it
    task automatic short_press(input int idx);
        wait (col_out[idx % 4] == 1'b1);
        wait (col_out[idx % 4] == 1'b0);
        hold_key(idx, SHORT_CYCLES);
    endtask

    task automatic type_number(input int n);  // always three digits
        press_key(digit_key(n / 100));
        press_key(digit_key((n / 10) % 10));
        press_key(digit_key(n % 10));
    endtask

    // compare process
    always @(negedge clk) begin
        if (nRST) begin
            if (UUT.key_ack)
                ack_count++;
            if (result_valid) begin
                pulse_count++;
                check_value("display_value", display_value, expected_display);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: key sequence still running after %0d cycles", cycle_count);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int                 a;
        int                 b;
        int                 op;
        int                 acks_before;
        logic signed [15:0] expected;
        void'($urandom(32'h706d4772));
        nRST     = 1'b1;
        held_key = -1;
        #DRIVE_DELAY nRST = 1'b0;  // clean falling edge for the async reset
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY nRST = 1'b1;
        @(negedge clk);
        check_value("display_value", display_value, 0);
        check_value("result_valid", result_valid, 0);
        check_value("col_out", col_out, 4'b1110);

        // every digit key, 67890 wraps to 2354
        press_key(14);
        for (int d = 1; d <= 5; d++)
            press_key(digit_key(d));
        press_key(14);
        for (int d = 6; d <= 10; d++)
            press_key(digit_key(d % 10));
        check_value("display_value", display_value, 2354);

        // random two operand sums, differences and products
        for (int i = 0; i < RAND_ITERS; i++) begin
            a  = $urandom % 1000;
            b  = $urandom % 1000;
            op = $urandom % 3;
            press_key(14);
            type_number(a);
            press_key(3 + 4 * op);  // add, sub, mul keys sit in column 3
            type_number(b);
            press_key(12);
            case (op)
                0:       expected = a + b;
                1:       expected = a - b;
                default: expected = a * b;
            endcase
            check_value("display_value", display_value, expected);
        end

        // 3 + 4 * 2 = runs left to right, then 14 - 5 =
        press_key(14);
        press_key(digit_key(3));
        press_key(3);
        press_key(digit_key(4));
        press_key(11);
        press_key(digit_key(2));
        press_key(12);
        check_value("display_value", display_value, 14);
        press_key(7);
        press_key(digit_key(5));
        press_key(12);
        check_value("display_value", display_value, 9);

        // negate entry, negate result, then clear
        press_key(14);
        press_key(digit_key(1));
        press_key(digit_key(2));
        press_key(15);
        check_value("display_value", display_value, -12);
        press_key(15);
        press_key(3);
        press_key(digit_key(5));
        press_key(12);
        press_key(15);
        check_value("display_value", display_value, -17);
        press_key(digit_key(3));
        check_value("display_value", display_value, -167);
        press_key(14);
        check_value("display_value", display_value, 0);

        // two short row pulses are each ignored, their counts must not add up
        press_key(14);
        press_key(digit_key(4));
        acks_before = ack_count;
        short_press(digit_key(8));
        short_press(digit_key(8));
        check_value("key_ack count", ack_count - acks_before, 0);
        check_value("display_value", display_value, 4);
        press_key(digit_key(8), LONG_CYCLES);  // long press counts once
        check_value("display_value", display_value, 48);

        $display("Regression passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hw/calc_pkg.sv
hw/calc_alu.sv
hw/keypad_scanner.sv
hw/calc_controller.sv
hw/calculator_top.sv
tests/calculator_assert.sv
tests/calculator_tb.sv

/* Bender.yml */
package:
  name: calculator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/calc_pkg.sv
      - hw/calc_alu.sv
      - hw/keypad_scanner.sv
      - hw/calc_controller.sv
      - hw/calculator_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/calculator_assert.sv
      - tests/calculator_tb.sv
